// File: hdl/video_pkg.sv
/*
 * text video package
 * raster timing, the vector types of the pipeline, the scan state encoding
 * and the 16 entry IRGB palette
 */
package video_pkg;

    typedef logic [10:0] pos_t;             // raster counter
    typedef logic [15:0] vram_addr_t;       // video memory word address
    typedef logic [15:0] vram_word_t;       // attribute in [15:8], char code in [7:0]
    typedef logic [12:0] font_addr_t;       // {0, char code, font row}
    typedef logic [3:0]  font_row_t;
    typedef logic [7:0]  font_byte_t;       // msb is the leftmost pixel
    typedef logic [3:0]  color_idx_t;
    typedef logic [11:0] rgb_t;             // 4 bits each of r, g, b
    typedef logic [3:0]  channel_t;

    // one state sequence shared by both axes
    typedef enum logic [1:0] {
        PRE_SYNC,
        SYNC,
        POST_SYNC,
        VISIBLE
    } scan_state_t;

    localparam int H_VISIBLE     = 64;
    localparam int H_FRONT_PORCH = 8;
    localparam int H_SYNC_PULSE  = 8;
    localparam int H_BACK_PORCH  = 16;
    localparam int H_TOTAL       = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int V_VISIBLE     = 32;
    localparam int V_FRONT_PORCH = 2;
    localparam int V_SYNC_PULSE  = 2;
    localparam int V_BACK_PORCH  = 4;
    localparam int V_TOTAL       = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    localparam logic H_SYNC_POLARITY = 1'b0;    // active low
    localparam logic V_SYNC_POLARITY = 1'b0;    // active low

    localparam int CHARS_WIDE  = 8;             // text row pitch in words
    localparam int FONT_HEIGHT = 16;

    // fetch runs one cell ahead of the visible span, window flips the cycle after these counts
    localparam pos_t H_FETCH_BEGIN = pos_t'(H_TOTAL - H_VISIBLE - 9);
    localparam pos_t H_FETCH_END   = pos_t'(H_TOTAL - 9);

    localparam rgb_t DEFAULT_PALETTE [16] = '{
        12'h000, 12'h00A, 12'h0A0, 12'h0AA,     // black, blue, green, cyan
        12'hA00, 12'hA0A, 12'hA50, 12'hAAA,     // red, magenta, brown, light gray
        12'h555, 12'h55F, 12'h5F5, 12'h5FF,     // bright set starts at index 8
        12'hF55, 12'hF5F, 12'hFF5, 12'hFFF
    };

endpackage

// File: hdl/scan_if.sv
/*
 * raster control bundle
 * made by the scan timing generator, read by the fetch and color stages
 */
`timescale 1ns/100ps

interface scan_if;

    logic visible;          // both axes in the visible state
    logic hsync;            // raw sync states, active high
    logic vsync;
    logic fetch_active;     // fetch window open on a visible line
    logic cell_start;       // window opens next cycle, restart cell column
    logic line_end;         // last pixel of a line
    logic frame_end;        // last pixel of the frame

    modport timing (
        output visible, hsync, vsync, fetch_active, cell_start, line_end, frame_end
    );

    modport fetch (
        input fetch_active, cell_start, line_end, frame_end
    );

    modport color (
        input visible, hsync, vsync
    );

endinterface

// File: hdl/scan_timing.sv
/*
 * scan timing generator
 * horizontal and vertical four state sequencers with position counters,
 * giving sync, visible area, fetch window and line and frame end strobes
 */
`timescale 1ns/100ps

module scan_timing (
    input  logic   clk,
    input  logic   reset_i,
    scan_if.timing scan
);
    import video_pkg::*;

    scan_state_t h_state;
    scan_state_t v_state;
    scan_state_t h_state_next;
    scan_state_t v_state_next;
    pos_t        h_count;
    pos_t        v_count;
    pos_t        h_limit;               // last count of the current h state
    pos_t        v_limit;               // last line of the current v state
    pos_t        fetch_toggle;          // count where the window flips next
    logic        fetch_q;
    logic        fetch_next;

    always_comb begin
        // porches and sync come before the visible pixels of a line
        case (h_state)
            PRE_SYNC:  h_limit = pos_t'(H_FRONT_PORCH - 1);
            SYNC:      h_limit = pos_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            POST_SYNC: h_limit = pos_t'(H_TOTAL - H_VISIBLE - 1);
            default:   h_limit = pos_t'(H_TOTAL - 1);
        endcase

        // visible lines first, blanking at the bottom
        case (v_state)
            VISIBLE:   v_limit = pos_t'(V_VISIBLE - 1);
            PRE_SYNC:  v_limit = pos_t'(V_VISIBLE + V_FRONT_PORCH - 1);
            SYNC:      v_limit = pos_t'(V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            default:   v_limit = pos_t'(V_TOTAL - 1);
        endcase
    end

    assign scan.line_end  = (h_state == VISIBLE) && (h_count == h_limit);
    assign scan.frame_end = scan.line_end && (v_state == POST_SYNC) && (v_count == v_limit);

    // states step when the counter hits the limit and VISIBLE wraps to PRE_SYNC
    assign h_state_next = (h_count == h_limit) ? scan_state_t'(h_state + 2'd1) : h_state;
    assign v_state_next = (scan.line_end && v_count == v_limit) ?
                          scan_state_t'(v_state + 2'd1) : v_state;

    assign fetch_toggle = fetch_q ? H_FETCH_END : H_FETCH_BEGIN;
    assign fetch_next   = (v_state == VISIBLE && h_count == fetch_toggle) ? ~fetch_q : fetch_q;

    assign scan.visible      = (h_state == VISIBLE) && (v_state == VISIBLE);
    assign scan.hsync        = (h_state == SYNC);
    assign scan.vsync        = (v_state == SYNC);
    assign scan.fetch_active = fetch_q;
    assign scan.cell_start   = ~fetch_q && fetch_next;     // rising edge of the window

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= PRE_SYNC;                            // start of front porch
            v_state <= VISIBLE;                             // on visible line 0
            h_count <= '0;
            v_count <= '0;
            fetch_q <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= scan.line_end ? pos_t'(0) : h_count + 11'd1;
            if (scan.line_end) begin
                v_count <= scan.frame_end ? pos_t'(0) : v_count + 11'd1;
            end
            fetch_q <= fetch_next;
        end
    end

    // sync pulse stays on its own counts ahead of the visible span
    a_hsync_blank : assert property (@(posedge clk) disable iff (reset_i)
        scan.hsync |-> (h_count >= pos_t'(H_FRONT_PORCH) &&
                        h_count < pos_t'(H_FRONT_PORCH + H_SYNC_PULSE)));

    // the next line opens at the start of the front porch
    a_line_wrap : assert property (@(posedge clk) disable iff (reset_i)
        scan.line_end |=> (h_state == PRE_SYNC && h_count == '0));

endmodule

// File: hdl/char_fetch.sv
/*
 * character fetch stage
 * per cell reads of char code and attribute from video memory, then the
 * font row byte, text address bookkeeping and the 8 bit pixel shifter
 */
`timescale 1ns/100ps

module char_fetch (
    input  logic                  clk,
    input  logic                  reset_i,
    scan_if.fetch                 scan,
    input  logic                  enable_i,
    input  video_pkg::vram_addr_t text_start_i,
    input  video_pkg::vram_word_t vram_data_i,
    input  video_pkg::font_byte_t font_data_i,
    output logic                  vram_sel_o,
    output video_pkg::vram_addr_t vram_addr_o,
    output logic                  fontram_sel_o,
    output video_pkg::font_addr_t fontram_addr_o,
    output logic                  font_pix_o,
    output video_pkg::color_idx_t fore_idx_o,
    output video_pkg::color_idx_t back_idx_o,
    output logic                  tg_enable_o
);
    import video_pkg::*;

    logic [2:0] char_x;             // cell column, sequences the memory access
    font_row_t  char_y;             // font row within the text row
    vram_addr_t text_addr;          // word for the next cell
    vram_addr_t line_addr;          // first word of the current text row
    vram_addr_t next_line_addr;
    font_byte_t shift_q;
    logic [7:0] attr_next;          // attribute of the cell being fetched
    logic [7:0] attr_q;             // attribute of the cell on screen
    logic       fetching;

    assign fetching       = tg_enable_o && scan.fetch_active;
    assign next_line_addr = line_addr + vram_addr_t'(CHARS_WIDE);

    // font address straight from the memory word, saves a cycle
    assign fontram_addr_o = {1'b0, vram_data_i[7:0], char_y};

    assign font_pix_o = shift_q[7];
    assign fore_idx_o = attr_q[3:0];
    assign back_idx_o = attr_q[7:4];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            char_x        <= '0;
            char_y        <= '0;
            text_addr     <= '0;
            line_addr     <= '0;
            tg_enable_o   <= 1'b0;
            vram_sel_o    <= 1'b0;
            fontram_sel_o <= 1'b0;
            vram_addr_o   <= '0;
        end else begin
            char_x <= scan.cell_start ? 3'd0 : char_x + 3'd1;

            // addr out in col 4, vram read in col 5, font read in col 6
            vram_sel_o    <= fetching && (char_x == 3'd4);
            fontram_sel_o <= fetching && (char_x == 3'd5);
            if (fetching && char_x == 3'd3) begin
                vram_addr_o <= text_addr;
            end
            if (fetching && char_x == 3'd7) begin
                text_addr <= text_addr + 16'd1;                 // next char+attribute
            end

            if (scan.line_end) begin
                if (char_y == font_row_t'(FONT_HEIGHT - 1)) begin
                    char_y    <= '0;                            // last font row, next text row
                    line_addr <= next_line_addr;
                    text_addr <= next_line_addr;
                end else begin
                    char_y    <= char_y + 4'd1;
                    text_addr <= line_addr;                     // same text row again
                end
            end

            // frame end wins over the line end in the same cycle
            if (scan.frame_end) begin
                tg_enable_o <= enable_i;
                char_y      <= '0;
                text_addr   <= text_start_i;
                line_addr   <= text_start_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        shift_q <= {shift_q[6:0], 1'b0};                        // one pixel per clock
        if (fetching && char_x == 3'd6) begin
            attr_next <= vram_data_i[15:8];                     // vram word valid in col 6
        end
        if (fetching && char_x == 3'd7) begin
            shift_q <= font_data_i;                             // font byte valid in col 7
            attr_q  <= attr_next;
        end
    end

    // selects only inside the window that scan timing opens
    a_vram_in_window : assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> scan.fetch_active);

endmodule

// File: hdl/pixel_color.sv
/*
 * pixel color stage
 * palette lookup of the font pixel, registered color, syncs and data valid
 */
`timescale 1ns/100ps

module pixel_color (
    input  logic                  clk,
    input  logic                  reset_i,
    scan_if.color                 scan,
    input  logic                  tg_enable_i,
    input  logic                  font_pix_i,
    input  video_pkg::color_idx_t fore_idx_i,
    input  video_pkg::color_idx_t back_idx_i,
    output video_pkg::channel_t   red_o,
    output video_pkg::channel_t   green_o,
    output video_pkg::channel_t   blue_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  dv_en_o
);
    import video_pkg::*;

    logic pix_on;
    rgb_t pix_rgb;

    assign pix_on = tg_enable_i && scan.visible;

    always_comb begin
        pix_rgb = '0;                                       // black off screen and when disabled
        if (pix_on) begin
            pix_rgb = font_pix_i ? DEFAULT_PALETTE[fore_idx_i] : DEFAULT_PALETTE[back_idx_i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
            hsync_o <= ~H_SYNC_POLARITY;                    // inactive level
            vsync_o <= ~V_SYNC_POLARITY;
            dv_en_o <= 1'b0;
        end else begin
            red_o   <= pix_rgb[11:8];
            green_o <= pix_rgb[7:4];
            blue_o  <= pix_rgb[3:0];
            hsync_o <= scan.hsync ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o <= scan.vsync ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_en_o <= pix_on;                              // lines up with the color
        end
    end

endmodule

// File: hdl/text_video.sv
/*
 * text mode video generator
 * scan timing, character fetch and pixel color stages with external
 * video and font memory ports and a 12 bit color video output
 */
`timescale 1ns/100ps

module text_video (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  enable_i,
    input  video_pkg::vram_addr_t text_start_i,
    output logic                  vram_sel_o,
    output video_pkg::vram_addr_t vram_addr_o,
    input  video_pkg::vram_word_t vram_data_i,
    output logic                  fontram_sel_o,
    output video_pkg::font_addr_t fontram_addr_o,
    input  video_pkg::font_byte_t fontram_data_i,
    output video_pkg::channel_t   red_o,
    output video_pkg::channel_t   green_o,
    output video_pkg::channel_t   blue_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  dv_en_o
);
    import video_pkg::*;

    logic       font_pix;
    color_idx_t fore_idx;
    color_idx_t back_idx;
    logic       tg_enable;          // enable as sampled at frame end

    scan_if scan ();

    scan_timing u_scan_timing (
        .clk     (clk),
        .reset_i (reset_i),
        .scan    (scan.timing)
    );

    char_fetch u_char_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .scan           (scan.fetch),
        .enable_i       (enable_i),
        .text_start_i   (text_start_i),
        .vram_data_i    (vram_data_i),
        .font_data_i    (fontram_data_i),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .fontram_sel_o  (fontram_sel_o),
        .fontram_addr_o (fontram_addr_o),
        .font_pix_o     (font_pix),
        .fore_idx_o     (fore_idx),
        .back_idx_o     (back_idx),
        .tg_enable_o    (tg_enable)
    );

    pixel_color u_pixel_color (
        .clk         (clk),
        .reset_i     (reset_i),
        .scan        (scan.color),
        .tg_enable_i (tg_enable),
        .font_pix_i  (font_pix),
        .fore_idx_i  (fore_idx),
        .back_idx_i  (back_idx),
        .red_o       (red_o),
        .green_o     (green_o),
        .blue_o      (blue_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .dv_en_o     (dv_en_o)
    );

endmodule

// File: verification/tb_text_video.sv
/*
 * testbench for the text mode video generator
 * models video and font memory, runs a table of enable and start address
 * settings frame by frame, checks syncs, data valid and every pixel color
 */
`timescale 1ns/100ps

module tb_text_video;
    import video_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int FRAME_PIXELS = H_VISIBLE * V_VISIBLE;
    localparam int NUM_ROWS     = 4;

    typedef struct packed {
        logic       en;
        vram_addr_t start;
        logic [3:0] frames;
    } row_t;

    // enable, text start, frames to observe
    row_t table_rows [NUM_ROWS] = '{
        '{1'b1, 16'h0000, 4'd2},
        '{1'b0, 16'h0040, 4'd1},                    // blank frame while the syncs keep running
        '{1'b1, 16'h0040, 4'd1},
        '{1'b1, 16'h0123, 4'd1}                     // new start takes effect next frame
    };

    logic       clk;
    logic       reset_i;
    logic       enable_i;
    vram_addr_t text_start_i;
    logic       vram_sel_o;
    vram_addr_t vram_addr_o;
    vram_word_t vram_data_i;
    logic       fontram_sel_o;
    font_addr_t fontram_addr_o;
    font_byte_t fontram_data_i;
    channel_t   red_o;
    channel_t   green_o;
    channel_t   blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_en_o;

    vram_word_t vram_mem [1024];
    font_byte_t font_mem [8192];
    logic       vram_sel_q;                         // memory requests seen at negedge
    vram_addr_t vram_addr_q;
    logic       font_sel_q;
    font_addr_t font_addr_q;

    int   errors;
    int   tests;
    int   failed_tests;
    int   hs_run;                                   // length of current hsync low pulse
    int   hs_pulses;                                // hsync pulses seen so far
    logic vs_prev;
    logic timed_out;

    text_video u_text_video (.*);

    always #50 clk = ~clk;                          // 100 ns period

    // one cycle registered reads
    always @(negedge clk) begin
        vram_sel_q  = vram_sel_o;
        vram_addr_q = vram_addr_o;
        font_sel_q  = fontram_sel_o;
        font_addr_q = fontram_addr_o;
    end

    always @(posedge clk) begin
        #1;
        if (vram_sel_q) vram_data_i = vram_mem[vram_addr_q[9:0]];
        if (font_sel_q) fontram_data_i = font_mem[font_addr_q];
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // color of the n-th visible pixel taken straight from the memory contents
    function automatic rgb_t expected_rgb(input vram_addr_t start, input int n);
        int         x;
        int         y;
        vram_addr_t a;
        vram_word_t w;
        font_byte_t fb;
        x  = n % H_VISIBLE;
        y  = n / H_VISIBLE;
        a  = start + vram_addr_t'((y / FONT_HEIGHT) * CHARS_WIDE + x / 8);
        w  = vram_mem[a[9:0]];
        fb = w[7:0] ^ font_byte_t'((y % FONT_HEIGHT) * 17);
        return fb[7 - (x % 8)] ? DEFAULT_PALETTE[w[11:8]] : DEFAULT_PALETTE[w[15:12]];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic check_hsync_width();
        if (!hsync_o) begin
            hs_run++;
        end else if (hs_run != 0) begin
            assert (hs_run == H_SYNC_PULSE) else report_mismatch("hsync_o low cycles",
                                                                 hs_run, H_SYNC_PULSE);
            hs_run = 0;
            hs_pulses++;
        end
    endtask

    // first frame after reset stays dark until the sampled enable changes
    task automatic idle_frame();
        int   cycles;
        int   err0;
        logic done;
        err0 = errors;
        done = 1'b0;
        cycles = 0;
        @(negedge clk);
        assert (hsync_o && vsync_o) else report_mismatch("{hsync_o,vsync_o}",
                                                         {hsync_o, vsync_o}, 2'b11);
        while (!done && cycles < 2 * FRAME_CYCLES) begin
            assert (!dv_en_o && !vram_sel_o && !fontram_sel_o && {red_o, green_o, blue_o} == 0)
            else begin
                $display("[FAIL] outputs active before the first frame end");
                errors++;
            end
            check_hsync_width();
            if (vs_prev && !vsync_o) done = 1'b1;
            vs_prev = vsync_o;
            if (!done) @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: no vsync pulse after reset");
            timed_out = 1'b1;
        end
        tests++;
        if (errors > err0) failed_tests++;
        $display("test %0d reset idle frame: %s", tests, (errors > err0) ? "fail" : "ok");
    endtask

    // one frame from vsync fall to vsync fall that holds the visible area of the new frame
    task automatic run_frame(input logic en, input vram_addr_t start);
        int   n;
        int   cycles;
        int   vs_low;
        int   dv_run;                               // length of current dv_en_o run
        int   hs0;
        int   err0;
        logic done;
        rgb_t got;
        n = 0;
        cycles = 0;
        vs_low = 0;
        dv_run = 0;
        hs0 = hs_pulses;
        err0 = errors;
        done = 1'b0;
        while (!done && cycles < FRAME_CYCLES + 16) begin
            @(negedge clk);
            cycles++;
            check_hsync_width();
            if (!vsync_o) vs_low++;
            got = {red_o, green_o, blue_o};
            if (dv_en_o) begin
                assert (got == expected_rgb(start, n))
                else report_mismatch($sformatf("rgb pixel %0d", n), got, expected_rgb(start, n));
                n++;
                dv_run++;
            end else begin
                assert (got == 0) else report_mismatch("rgb outside dv_en_o", got, 0);
                if (dv_run != 0) begin
                    assert (dv_run == H_VISIBLE)
                    else report_mismatch("dv_en_o high cycles", dv_run, H_VISIBLE);
                    dv_run = 0;
                end
            end
            if (!en) begin
                assert (!vram_sel_o && !fontram_sel_o) else begin
                    $display("[FAIL] memory selected while the display is disabled");
                    errors++;
                end
            end
            if (vs_prev && !vsync_o) done = 1'b1;
            vs_prev = vsync_o;
            if (dv_en_o && n == FRAME_PIXELS / 2) begin
                @(posedge clk);
                #1 text_start_i = start + 16'h0100;     // mid frame change must not show
            end
        end
        if (!done) begin
            $display("timeout: vsync pulse missing within a frame");
            timed_out = 1'b1;
        end
        assert (cycles == FRAME_CYCLES) else report_mismatch("frame cycles", cycles, FRAME_CYCLES);
        assert (vs_low == V_SYNC_PULSE * H_TOTAL)
        else report_mismatch("vsync_o low cycles", vs_low, V_SYNC_PULSE * H_TOTAL);
        assert (hs_pulses - hs0 == V_TOTAL)
        else report_mismatch("hsync_o pulses", hs_pulses - hs0, V_TOTAL);
        assert (n == (en ? FRAME_PIXELS : 0))
        else report_mismatch("dv_en_o pulses", n, en ? FRAME_PIXELS : 0);
        tests++;
        if (errors > err0) failed_tests++;
        $display("test %0d frame en=%0d start=0x%04h: %s", tests, en, start,
                 (errors > err0) ? "fail" : "ok");
    endtask

    initial begin
        logic [31:0] lfsr;
        vram_word_t  w;
        clk = 1'b0;
        reset_i = 1'b1;
        enable_i = 1'b0;
        text_start_i = '0;
        vram_data_i = '0;
        fontram_data_i = '0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        hs_run = 0;
        hs_pulses = 0;
        vs_prev = 1'b1;
        timed_out = 1'b0;

        lfsr = 32'h5805_bb3f;
        for (int a = 0; a < 1024; a++) begin
            w = '0;
            for (int b = 0; b < 16; b++) begin
                w = {w[14:0], lfsr[0]};                     // one lfsr step per bit
                lfsr = lfsr_next(lfsr);
            end
            vram_mem[a] = w;
        end
        for (int a = 0; a < 8192; a++) begin
            // upper half is inverted and never addressed by the font fetch
            font_mem[a] = font_byte_t'(a >> 4) ^ font_byte_t'((a % 16) * 17) ^ {8{a[12]}};
        end

        repeat (16) @(posedge clk);
        #1 reset_i = 1'b0;

        idle_frame();
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int f = 0; f < int'(table_rows[r].frames); f++) begin
                if (!timed_out) begin
                    @(posedge clk);
                    #1;
                    enable_i = table_rows[r].en;            // sampled at the coming frame end
                    text_start_i = table_rows[r].start;
                    run_frame(table_rows[r].en, table_rows[r].start);
                end
            end
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/video_pkg.sv
hdl/scan_if.sv
hdl/scan_timing.sv
hdl/char_fetch.sv
hdl/pixel_color.sv
hdl/text_video.sv
verification/tb_text_video.sv

// File: run_sim.sh
#!/bin/sh
# build and run the text video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_text_video -o sim_text_video

sim_out=$(./obj_dir/sim_text_video)
echo "$sim_out"

echo "$sim_out" | grep -q "ALL TESTS PASSED"
